// ==== ps2KeyboardTop.f ====
src/ps2Pkg.sv
src/ps2Ifs.sv
src/ps2LineMonitor.sv
src/ps2FrameReceiver.sv
src/ps2ScanDecoder.sv
src/apbKeyRegs.sv
src/ps2KeyboardTop.sv
tb/tbClockGen.sv
tb/ps2KeyboardTop_assert.sv
tb/tbPs2Keyboard.sv

// ==== run.sh ====
#!/bin/sh
# Builds the PS/2 keyboard testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbPs2Keyboard \
	-f ps2KeyboardTop.f -o simv
./obj_dir/simv 2>&1 | tee sim.log
if grep -q "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== src/apbKeyRegs.sv ====
// APB key registers: holding register, sticky status flags, modifier view, interrupt
`timescale 1ns/10ps

module apbKeyRegs #(
	parameter int ADDR_W = 4
) (
	input  logic              CLOCK,
	input  logic              RST_n,
	input  logic              PSEL,
	input  logic              PENABLE,
	input  logic              PWRITE,
	input  logic [ADDR_W-1:0] PADDR,
	input  logic [31:0]       PWDATA,
	keyEventIf.sink           keyEv,
	input  logic              timeoutPulse,
	output logic [31:0]       PRDATA,
	output logic              PREADY,
	output logic              PSLVERR,
	output logic              IRQ
);
	localparam logic [ADDR_W-1:0] A_STATUS = ADDR_W'(ps2Pkg::REG_STATUS);
	localparam logic [ADDR_W-1:0] A_KEY    = ADDR_W'(ps2Pkg::REG_KEY);
	localparam logic [ADDR_W-1:0] A_MODS   = ADDR_W'(ps2Pkg::REG_MODS);
	localparam logic [ADDR_W-1:0] A_CTRL   = ADDR_W'(ps2Pkg::REG_CTRL);

	logic       wrEn;        // Access phase write
	logic       wrStatus;
	logic       rdKey;       // KEY read clears keyValid
	logic       keyValidR;
	logic       overflowR;
	logic       parityErrR;
	logic       timeoutR;
	logic       enableR;
	logic [9:0] keyReg;      // {break, extended, code}

	assign PREADY   = 1'b1; // No wait states
	assign PSLVERR  = 1'b0;
	assign wrEn     = PSEL & PENABLE & PWRITE;
	assign wrStatus = wrEn & (PADDR == A_STATUS);
	assign rdKey    = PSEL & PENABLE & ~PWRITE & (PADDR == A_KEY);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			keyValidR  <= 1'b0;
			overflowR  <= 1'b0;
			parityErrR <= 1'b0;
			timeoutR   <= 1'b0;
			enableR    <= 1'b1; // Interrupt on by default
		end else begin
			if (keyEv.keyValid)
				keyValidR <= 1'b1;
			else if (rdKey)
				keyValidR <= 1'b0;
			// Event into a full, unread holding register
			if (keyEv.keyValid && keyValidR && !rdKey)
				overflowR <= 1'b1;
			else if (wrStatus && PWDATA[1])
				overflowR <= 1'b0;
			if (keyEv.errPulse)
				parityErrR <= 1'b1;
			else if (wrStatus && PWDATA[2])
				parityErrR <= 1'b0;
			if (timeoutPulse)
				timeoutR <= 1'b1;
			else if (wrStatus && PWDATA[3])
				timeoutR <= 1'b0;
			if (wrEn && PADDR == A_CTRL)
				enableR <= PWDATA[0];
		end
	end

	// Latest key, overwritten on overflow
	always_ff @(posedge CLOCK) begin
		if (keyEv.keyValid)
			keyReg <= {keyEv.isBreak, keyEv.extended, keyEv.code};
	end

	// Read mux
	always_comb begin
		case (PADDR)
			A_STATUS: PRDATA = {28'd0, timeoutR, parityErrR, overflowR, keyValidR};
			A_KEY:    PRDATA = {22'd0, keyReg};
			A_MODS:   PRDATA = {26'd0, keyEv.mods}; // Live state
			A_CTRL:   PRDATA = {31'd0, enableR};
			default:  PRDATA = 32'd0;
		endcase
	end

	assign IRQ = keyValidR & enableR;

endmodule

// ==== src/ps2FrameReceiver.sv ====
// PS/2 frame receiver: assembles start, 8 data, odd parity and stop bits into checked bytes
`timescale 1ns/10ps

module ps2FrameReceiver (
	input  logic             CLOCK,
	input  logic             RST_n,
	input  logic             fallPulse,
	input  logic             dataBit,
	input  logic             timeoutPulse,
	output logic             inFrame,
	ps2FrameIf.source        frame
);
	logic [3:0] bitCnt;   // 0 start, 1..8 data, 9 parity, 10 stop
	logic [7:0] shiftReg;
	logic       parityBit;
	logic       startBad; // Start bit sampled high

	assign inFrame = (bitCnt != 4'd0);

	// Bit position and frame strobe
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			bitCnt           <= 4'd0;
			frame.frameValid <= 1'b0;
		end else begin
			frame.frameValid <= 1'b0;
			if (timeoutPulse) begin
				bitCnt <= 4'd0; // Partial frame discarded
			end else if (fallPulse) begin
				if (bitCnt == 4'd10) begin
					bitCnt           <= 4'd0;
					frame.frameValid <= 1'b1;
				end else begin
					bitCnt <= bitCnt + 4'd1;
				end
			end
		end
	end

	// Data path
	always_ff @(posedge CLOCK) begin
		if (fallPulse) begin
			case (bitCnt)
				4'd0: startBad <= dataBit;
				4'd9: parityBit <= dataBit;
				4'd10: begin
					frame.frameData <= shiftReg;
					frame.parityErr <= ~^{shiftReg, parityBit}; // Odd parity expected
					frame.frameErr  <= startBad | ~dataBit;      // Stop bit must be high
				end
				default: shiftReg <= {dataBit, shiftReg[7:1]}; // LSB first
			endcase
		end
	end

endmodule

// ==== src/ps2Ifs.sv ====
// Internal buses of the PS/2 receiver: received frames and decoded key events
`timescale 1ns/10ps

// One byte per frameValid pulse, errors valid with the pulse
interface ps2FrameIf;
	logic       frameValid;
	logic [7:0] frameData;
	logic       parityErr;
	logic       frameErr;  // Bad start or stop bit

	modport source (output frameValid, frameData, parityErr, frameErr);
	modport sink   (input frameValid, frameData, parityErr, frameErr);
endinterface

// Key events toward the register block
interface keyEventIf;
	logic        keyValid;  // One-cycle pulse
	logic [7:0]  code;
	logic        extended;
	logic        isBreak;
	ps2Pkg::modT mods;      // Live modifier state
	logic        errPulse;  // Sequence dropped on a bad frame

	modport source (output keyValid, code, extended, isBreak, mods, errPulse);
	modport sink   (input keyValid, code, extended, isBreak, mods, errPulse);
endinterface

// ==== src/ps2KeyboardTop.sv ====
// PS/2 keyboard receiver top: line monitor, frame receiver, scan decoder and APB registers
`timescale 1ns/10ps

module ps2KeyboardTop #(
	parameter int TIMEOUT_CYCLES = 64, // Idle cycles before a frame is dropped
	parameter int ADDR_W         = 4
) (
	input  logic              CLOCK,
	input  logic              RST_n,
	input  logic              PS2_CLK,
	input  logic              PS2_DAT,
	input  logic              PSEL,
	input  logic              PENABLE,
	input  logic              PWRITE,
	input  logic [ADDR_W-1:0] PADDR,
	input  logic [31:0]       PWDATA,
	output logic [31:0]       PRDATA,
	output logic              PREADY,
	output logic              PSLVERR,
	output logic              IRQ
);
	logic fallPulse;
	logic dataBit;
	logic inFrame;
	logic timeoutPulse; // To receiver, decoder and status

	ps2FrameIf frameBus ();
	keyEventIf keyBus ();

	ps2LineMonitor #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) i_ps2LineMonitor (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.ps2Clk(PS2_CLK),
		.ps2Dat(PS2_DAT),
		.inFrame(inFrame),
		.fallPulse(fallPulse),
		.dataBit(dataBit),
		.timeoutPulse(timeoutPulse)
	);

	ps2FrameReceiver i_ps2FrameReceiver (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.fallPulse(fallPulse),
		.dataBit(dataBit),
		.timeoutPulse(timeoutPulse),
		.inFrame(inFrame),
		.frame(frameBus.source)
	);

	ps2ScanDecoder i_ps2ScanDecoder (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.timeoutPulse(timeoutPulse),
		.frame(frameBus.sink),
		.keyEv(keyBus.source)
	);

	apbKeyRegs #(
		.ADDR_W(ADDR_W)
	) i_apbKeyRegs (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.keyEv(keyBus.sink),
		.timeoutPulse(timeoutPulse),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.IRQ(IRQ)
	);

endmodule

// ==== src/ps2LineMonitor.sv ====
// PS/2 line monitor: synchronizes the lines, flags falling clock edges, times out stalled frames
`timescale 1ns/10ps

module ps2LineMonitor #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic CLOCK,
	input  logic RST_n,
	input  logic ps2Clk,
	input  logic ps2Dat,
	input  logic inFrame,
	output logic fallPulse,
	output logic dataBit,
	output logic timeoutPulse
);
	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TIMEOUT_CYCLES - 1);
	localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(TIMEOUT_CYCLES);

	logic [1:0]       clkSync;
	logic [1:0]       datSync;
	logic             clkPrev;  // Previous synchronized clock
	logic [CNT_W-1:0] idleCnt;  // Cycles since last fall

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			clkSync   <= 2'b11; // Idle bus is high
			datSync   <= 2'b11;
			clkPrev   <= 1'b1;
			fallPulse <= 1'b0;
			dataBit   <= 1'b1;
		end else begin
			clkSync   <= {clkSync[0], ps2Clk};
			datSync   <= {datSync[0], ps2Dat};
			clkPrev   <= clkSync[1];
			fallPulse <= clkPrev & ~clkSync[1]; // High to low
			dataBit   <= datSync[1];            // Aligned with fallPulse
		end
	end

	// Idle timer, runs only inside a frame
	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			idleCnt      <= '0;
			timeoutPulse <= 1'b0;
		end else begin
			timeoutPulse <= inFrame & ~fallPulse & (idleCnt == CNT_LAST);
			if (fallPulse)
				idleCnt <= CNT_W'(1); // Restart on every bit
			else if (!inFrame)
				idleCnt <= '0;
			else if (idleCnt != CNT_MAX)
				idleCnt <= idleCnt + CNT_W'(1); // Saturates, no second pulse
		end
	end

endmodule

// ==== src/ps2Pkg.sv ====
// PS/2 keyboard shared definitions: set-2 sequences, modifier bits, APB register map
package ps2Pkg;

	// Set-2 prefix bytes
	localparam logic [7:0] EXT_PREFIX = 8'hE0;
	localparam logic [7:0] BRK_PREFIX = 8'hF0;

	// Modifier sequences, packed as prefix, break, code
	localparam logic [23:0] MAKE_LSHIFT = 24'h00_00_12;
	localparam logic [23:0] MAKE_LCTRL  = 24'h00_00_14;
	localparam logic [23:0] MAKE_LALT   = 24'h00_00_11;
	localparam logic [23:0] MAKE_RSHIFT = 24'h00_00_59;
	localparam logic [23:0] MAKE_RCTRL  = 24'hE0_00_14; // Right side keys are extended
	localparam logic [23:0] MAKE_RALT   = 24'hE0_00_11;
	localparam logic [23:0] BRK_LSHIFT  = 24'h00_F0_12;
	localparam logic [23:0] BRK_LCTRL   = 24'h00_F0_14;
	localparam logic [23:0] BRK_LALT    = 24'h00_F0_11;
	localparam logic [23:0] BRK_RSHIFT  = 24'h00_F0_59;
	localparam logic [23:0] BRK_RCTRL   = 24'hE0_F0_14;
	localparam logic [23:0] BRK_RALT    = 24'hE0_F0_11;

	// Modifier flag positions
	localparam int MOD_RSHIFT = 5;
	localparam int MOD_RCTRL  = 4;
	localparam int MOD_RALT   = 3;
	localparam int MOD_LSHIFT = 2;
	localparam int MOD_LCTRL  = 1;
	localparam int MOD_LALT   = 0;

	// APB register offsets
	localparam logic [3:0] REG_STATUS = 4'h0;
	localparam logic [3:0] REG_KEY    = 4'h4;
	localparam logic [3:0] REG_MODS   = 4'h8;
	localparam logic [3:0] REG_CTRL   = 4'hC;

	typedef logic [5:0] modT;

	// Sequence word, matched as a whole or built byte by byte
	typedef union packed {
		logic [23:0] raw;
		struct packed {
			logic [7:0] prefix; // E0 or zero
			logic [7:0] brk;    // F0 or zero
			logic [7:0] code;
		} bytes;
	} keyCodeU;

endpackage

// ==== src/ps2ScanDecoder.sv ====
// Set-2 scan decoder: merges E0/F0 prefixes, tracks modifiers, emits make events
`timescale 1ns/10ps

module ps2ScanDecoder (
	input  logic       CLOCK,
	input  logic       RST_n,
	input  logic       timeoutPulse,
	ps2FrameIf.sink    frame,
	keyEventIf.source  keyEv
);
	localparam logic [1:0] IDLE    = 2'd0;
	localparam logic [1:0] GOT_EXT = 2'd1; // After E0
	localparam logic [1:0] GOT_BRK = 2'd2; // After F0 or E0 F0
	localparam logic [1:0] RESOLVE = 2'd3; // One cycle

	logic [1:0]      state;
	ps2Pkg::keyCodeU keyWord;
	ps2Pkg::modT     modsReg;
	ps2Pkg::modT     modsNext;
	logic            emitKey;
	logic            goodFrame;

	assign goodFrame = frame.frameValid & ~frame.parityErr & ~frame.frameErr;

	// Sequence resolution
	always_comb begin
		modsNext = modsReg;
		emitKey  = 1'b0;
		if (state == RESOLVE) begin
			case (keyWord.raw)
				ps2Pkg::MAKE_RSHIFT: modsNext[ps2Pkg::MOD_RSHIFT] = 1'b1;
				ps2Pkg::MAKE_RCTRL:  modsNext[ps2Pkg::MOD_RCTRL] = 1'b1;
				ps2Pkg::MAKE_RALT:   modsNext[ps2Pkg::MOD_RALT] = 1'b1;
				ps2Pkg::MAKE_LSHIFT: modsNext[ps2Pkg::MOD_LSHIFT] = 1'b1;
				ps2Pkg::MAKE_LCTRL:  modsNext[ps2Pkg::MOD_LCTRL] = 1'b1;
				ps2Pkg::MAKE_LALT:   modsNext[ps2Pkg::MOD_LALT] = 1'b1;
				ps2Pkg::BRK_RSHIFT:  modsNext[ps2Pkg::MOD_RSHIFT] = 1'b0;
				ps2Pkg::BRK_RCTRL:   modsNext[ps2Pkg::MOD_RCTRL] = 1'b0;
				ps2Pkg::BRK_RALT:    modsNext[ps2Pkg::MOD_RALT] = 1'b0;
				ps2Pkg::BRK_LSHIFT:  modsNext[ps2Pkg::MOD_LSHIFT] = 1'b0;
				ps2Pkg::BRK_LCTRL:   modsNext[ps2Pkg::MOD_LCTRL] = 1'b0;
				ps2Pkg::BRK_LALT:    modsNext[ps2Pkg::MOD_LALT] = 1'b0;
				default: emitKey = (keyWord.bytes.brk != ps2Pkg::BRK_PREFIX); // Other breaks dropped
			endcase
		end
	end

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			state          <= IDLE;
			keyWord        <= '0;
			modsReg        <= '0;
			keyEv.errPulse <= 1'b0;
		end else begin
			keyEv.errPulse <= frame.frameValid & (frame.parityErr | frame.frameErr);
			modsReg        <= modsNext;
			if (timeoutPulse || (frame.frameValid && !goodFrame)) begin
				state   <= IDLE; // Restart sequence
				keyWord <= '0;
			end else begin
				case (state)
					IDLE, GOT_EXT: if (goodFrame) begin
						if (frame.frameData == ps2Pkg::EXT_PREFIX) begin
							keyWord.bytes.prefix <= frame.frameData;
							state                <= GOT_EXT;
						end else if (frame.frameData == ps2Pkg::BRK_PREFIX) begin
							keyWord.bytes.brk <= frame.frameData;
							state             <= GOT_BRK;
						end else begin
							keyWord.bytes.code <= frame.frameData;
							state              <= RESOLVE;
						end
					end
					GOT_BRK: if (goodFrame) begin
						keyWord.bytes.code <= frame.frameData; // Released key
						state              <= RESOLVE;
					end
					default: begin
						keyWord <= '0;
						state   <= IDLE;
					end
				endcase
			end
		end
	end

	// Event out during RESOLVE
	assign keyEv.keyValid = emitKey;
	assign keyEv.code     = keyWord.bytes.code;
	assign keyEv.extended = (keyWord.bytes.prefix == ps2Pkg::EXT_PREFIX);
	assign keyEv.isBreak  = (keyWord.bytes.brk == ps2Pkg::BRK_PREFIX);
	assign keyEv.mods     = modsNext; // Shows the update in the same cycle

endmodule

// ==== tb/ps2KeyboardTop_assert.sv ====
// Bound checks on the keyboard top: APB response signals and interrupt behavior
`timescale 1ns/10ps

module ps2KeyboardTop_assert (
	input logic       CLOCK,
	input logic       RST_n,
	input logic       PSEL,
	input logic       PENABLE,
	input logic       PWRITE,
	input logic [3:0] PADDR,
	input logic       PREADY,
	input logic       PSLVERR,
	input logic       IRQ,
	input logic       keyEvent     // Decoder key pulse
);
	logic seenKey; // Any key event since reset
	logic keyHeld; // Key not yet read over APB
	logic keyRead; // KEY read in the access phase

	assign keyRead = PSEL & PENABLE & ~PWRITE & (PADDR == ps2Pkg::REG_KEY);

	always_ff @(posedge CLOCK or negedge RST_n) begin
		if (!RST_n) begin
			seenKey <= 1'b0;
			keyHeld <= 1'b0;
		end else if (keyEvent) begin
			seenKey <= 1'b1;
			keyHeld <= 1'b1; // New key wins over a read
		end else if (keyRead) begin
			keyHeld <= 1'b0;
		end
	end

	readyHigh: assert property (@(posedge CLOCK) disable iff (!RST_n) PREADY)
		else $error("PREADY went low");
	noSlvErr: assert property (@(posedge CLOCK) disable iff (!RST_n) !PSLVERR)
		else $error("PSLVERR went high");
	irqNeedsKey: assert property (@(posedge CLOCK) disable iff (!RST_n) IRQ |-> keyHeld)
		else $error("IRQ high without a held key");
	quietAfterReset: assert property (@(posedge CLOCK) disable iff (!RST_n) !seenKey |-> !IRQ)
		else $error("IRQ high before any key event");

endmodule

bind ps2KeyboardTop ps2KeyboardTop_assert i_ps2KeyboardTop_assert (
	.CLOCK(CLOCK),
	.RST_n(RST_n),
	.PSEL(PSEL),
	.PENABLE(PENABLE),
	.PWRITE(PWRITE),
	.PADDR(PADDR),
	.PREADY(PREADY),
	.PSLVERR(PSLVERR),
	.IRQ(IRQ),
	.keyEvent(keyBus.keyValid)
);

// ==== tb/ps2_patterns.txt ====
// cnt b0 b1 b2 flag key mods status   (hex, key is {break, ext, code})
// flag 01 bad parity on last byte, 02 truncate, 04 read KEY, 08 clear flags, 10 IRQ off, 20 IRQ on
1 1C 00 00 04 01C 00 1
2 E0 75 00 04 175 00 1
1 12 00 00 00 000 04 0
2 E0 14 00 00 000 14 0
2 F0 12 00 00 000 10 0
3 E0 F0 14 00 000 00 0
2 F0 1C 00 00 000 00 0
1 1C 00 00 00 000 00 1
1 32 00 00 0C 032 00 3
1 1C 00 00 01 000 00 4
1 1C 00 00 0A 000 00 C
1 1C 00 00 04 01C 00 1
1 5A 00 00 34 05A 00 1
2 E0 11 00 00 000 08 0
3 E0 F0 11 00 000 00 0
1 59 00 00 00 000 20 0
2 F0 59 00 00 000 00 0
1 11 00 00 00 000 01 0
1 14 00 00 00 000 03 0
2 E0 6B 00 04 16B 03 1
2 F0 14 00 00 000 01 0
2 F0 11 00 00 000 00 0
0 00 00 00 00 000 00 0

// ==== tb/tbClockGen.sv ====
// Testbench clock source: 4 ns CLOCK and an active-low reset held for three cycles
`timescale 1ns/10ps

module tbClockGen (
	output logic CLOCK,
	output logic RST_n
);
	initial CLOCK = 1'b0;
	always #2 CLOCK = ~CLOCK; // 250 MHz

	initial begin
		RST_n = 1'b0;
		repeat (3) @(negedge CLOCK);
		RST_n = 1'b1; // Released away from the active edge
	end

endmodule

// ==== tb/tbPs2Keyboard.sv ====
// PS/2 keyboard testbench: replays scan-code patterns over PS/2 and checks the APB registers
`timescale 1ns/10ps

module tbPs2Keyboard;
	localparam int MAX_PAT = 32;
	localparam int FIELDS  = 8; // cnt, 3 bytes, flag, key, mods, status

	logic        CLOCK;
	logic        RST_n;
	logic        PS2_CLK;
	logic        PS2_DAT;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [3:0]  PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic        IRQ;

	logic [11:0] patMem [0:MAX_PAT*FIELDS-1];
	int          errCount;
	int          checkCount;
	integer      seed;
	logic        enableExp; // Model of CTRL.enable

	tbClockGen i_tbClockGen (
		.CLOCK(CLOCK),
		.RST_n(RST_n)
	);

	ps2KeyboardTop i_ps2KeyboardTop (
		.CLOCK(CLOCK),
		.RST_n(RST_n),
		.PS2_CLK(PS2_CLK),
		.PS2_DAT(PS2_DAT),
		.PSEL(PSEL),
		.PENABLE(PENABLE),
		.PWRITE(PWRITE),
		.PADDR(PADDR),
		.PWDATA(PWDATA),
		.PRDATA(PRDATA),
		.PREADY(PREADY),
		.PSLVERR(PSLVERR),
		.IRQ(IRQ)
	);

	task automatic checkKey(input logic [9:0] exp, input logic [9:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR KEY expected %03h actual %03h", exp, act);
		end
	endtask

	task automatic checkMods(input ps2Pkg::modT exp, input ps2Pkg::modT act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR MODS expected %02h actual %02h", exp, act);
		end
	endtask

	task automatic checkStatus(input logic [3:0] exp, input logic [3:0] act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR STATUS expected %01h actual %01h", exp, act);
		end
	endtask

	task automatic checkIrq(input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errCount++;
			$display("ERR IRQ expected %01h actual %01h", exp, act);
		end
	endtask

	// One PS/2 frame, device side; nBits below 11 leaves the frame hanging
	task automatic sendFrame(input logic [7:0] data, input logic badPar, input int nBits);
		logic [10:0] bits;
		int          i;
		bits = {1'b1, ~(^data) ^ badPar, data, 1'b0}; // Stop, odd parity, data, start
		for (i = 0; i < nBits; i++) begin
			@(negedge CLOCK);
			PS2_DAT = bits[i];
			repeat (8) @(negedge CLOCK);
			PS2_CLK = 1'b0; // Host samples on this fall
			repeat (8) @(negedge CLOCK);
			PS2_CLK = 1'b1;
		end
		PS2_DAT = 1'b1;
	endtask

	// APB setup and access phases, PREADY polled
	task automatic apbAccess(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waitCnt;
		@(negedge CLOCK);
		PSEL    = 1'b1;
		PWRITE  = wr;
		PADDR   = addr;
		PWDATA  = wdata;
		PENABLE = 1'b0;
		@(negedge CLOCK);
		PENABLE = 1'b1;
		waitCnt = 0;
		#1;
		while (PREADY !== 1'b1 && waitCnt < 16) begin
			@(negedge CLOCK);
			#1;
			waitCnt++;
		end
		if (PREADY !== 1'b1) begin
			errCount++;
			$display("APB transfer to %01h never got PREADY", addr);
		end
		rdata = PRDATA; // Stable mid low phase
		@(negedge CLOCK);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
	endtask

	// Poll STATUS until it settles on the expected flags
	task automatic waitStatus(input logic [3:0] exp);
		logic [31:0] rd;
		int          tries;
		tries = 0;
		apbAccess(1'b0, ps2Pkg::REG_STATUS, 32'd0, rd);
		while (rd[3:0] !== exp && tries < 200) begin
			apbAccess(1'b0, ps2Pkg::REG_STATUS, 32'd0, rd);
			tries++;
		end
		if (rd[3:0] !== exp) begin
			errCount++;
			$display("Timed out waiting for STATUS to reach %01h", exp);
		end
	endtask

	initial begin
		int          p;
		int          i;
		int          base;
		int          nBytes;
		int          gap;
		int          tries;
		logic [7:0]  flag;
		logic [3:0]  expStatus;
		logic [3:0]  statusNow;
		logic [31:0] rd;
		PS2_CLK    = 1'b1; // Idle bus
		PS2_DAT    = 1'b1;
		PSEL       = 1'b0;
		PENABLE    = 1'b0;
		PWRITE     = 1'b0;
		PADDR      = '0;
		PWDATA     = '0;
		errCount   = 0;
		checkCount = 0;
		seed       = 32'h0e697884;
		enableExp  = 1'b1;
		for (p = 0; p < MAX_PAT * FIELDS; p++)
			patMem[p] = '0;
		$readmemh("tb/ps2_patterns.txt", patMem);

		tries = 0;
		while (RST_n !== 1'b1 && tries < 20) begin
			@(negedge CLOCK);
			tries++;
		end
		if (RST_n !== 1'b1) begin
			errCount++;
			$display("Reset was never released");
		end

		// Reset state
		apbAccess(1'b0, ps2Pkg::REG_STATUS, 32'd0, rd);
		checkStatus(4'h0, rd[3:0]);
		apbAccess(1'b0, ps2Pkg::REG_MODS, 32'd0, rd);
		checkMods('0, rd[5:0]);
		checkIrq(1'b0, IRQ);

		for (p = 0; p < MAX_PAT; p++) begin
			base   = p * FIELDS;
			nBytes = int'(patMem[base]);
			if (nBytes == 0)
				break; // End marker
			flag      = patMem[base+4][7:0];
			expStatus = patMem[base+7][3:0];
			if (flag[4]) begin
				apbAccess(1'b1, ps2Pkg::REG_CTRL, 32'd0, rd); // IRQ off
				enableExp = 1'b0;
			end
			if (flag[1]) begin
				sendFrame(patMem[base+1][7:0], 1'b0, 5); // Stalls after five bits
			end else begin
				for (i = 0; i < nBytes; i++) begin
					sendFrame(patMem[base+1+i][7:0], flag[0] && (i == nBytes - 1), 11);
					gap = 6 + ({$random(seed)} % 10);
					repeat (gap) @(negedge CLOCK);
				end
			end
			waitStatus(expStatus);
			apbAccess(1'b0, ps2Pkg::REG_STATUS, 32'd0, rd);
			checkStatus(expStatus, rd[3:0]);
			apbAccess(1'b0, ps2Pkg::REG_MODS, 32'd0, rd);
			checkMods(patMem[base+6][5:0], rd[5:0]);
			checkIrq(expStatus[0] & enableExp, IRQ);
			statusNow = expStatus;
			if (flag[2]) begin
				apbAccess(1'b0, ps2Pkg::REG_KEY, 32'd0, rd);
				checkKey(patMem[base+5][9:0], rd[9:0]);
				statusNow[0] = 1'b0; // Read clears keyValid
			end
			if (flag[3]) begin
				apbAccess(1'b1, ps2Pkg::REG_STATUS, 32'h0000_000E, rd);
				statusNow[3:1] = 3'b000;
			end
			if (flag[2] || flag[3]) begin
				apbAccess(1'b0, ps2Pkg::REG_STATUS, 32'd0, rd);
				checkStatus(statusNow, rd[3:0]);
				checkIrq(statusNow[0] & enableExp, IRQ);
			end
			if (flag[5]) begin
				apbAccess(1'b1, ps2Pkg::REG_CTRL, 32'd1, rd);
				enableExp = 1'b1;
			end
		end
		if (p == 0) begin
			errCount++;
			$display("No patterns were loaded");
		end

		$display("Patterns %0d, checks %0d, errors %0d", p, checkCount, errCount);
		if (errCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
